/* hw/rb_pipe_pkg.sv */
// strand count and all widths are fixed here; a strand ID wider than 2 bits needs STRAND_W changed too
package rb_pipe_pkg;

	// four hardware strands share the pipeline
	localparam int NUM_STRANDS = 4;
	localparam int STRAND_W = 2;

	// datapath widths
	localparam int PC_W = 32;
	localparam int OFFSET_W = 32;
	localparam int LANE_W = 4;

	// rollback counters wrap at this width
	localparam int CNT_W = 32;

	typedef logic [STRAND_W-1:0] strand_t;

	// strand id held by each pipeline position, fetch side first
	typedef struct packed {
		strand_t ss;
		strand_t ds;
		// ex is the strand leaving execute, ex1..ex3 sit in the multi-cycle path
		strand_t ex;
		strand_t ex1;
		strand_t ex2;
		strand_t ex3;
		strand_t ma;
	} stage_strands_t;

	// execute request, always aimed at the ds strand
	typedef struct packed {
		logic valid;
		logic [PC_W-1:0] pc;
	} ex_rollback_t;

	// writeback request, always aimed at the ma strand
	typedef struct packed {
		logic valid;
		logic retry;
		logic suspend;
		logic [PC_W-1:0] pc;
		logic [OFFSET_W-1:0] strided_offset;
		logic [LANE_W-1:0] reg_lane;
	} wb_rollback_t;

	typedef struct packed {
		logic ds;
		logic ex0;
		logic ex1;
		logic ex2;
		logic ex3;
		logic ma;
	} flush_t;

	// per-strand restart bundle handed back to fetch
	typedef struct packed {
		logic rollback;
		logic retry;
		logic suspend;
		logic [PC_W-1:0] pc;
		logic [OFFSET_W-1:0] strided_offset;
		logic [LANE_W-1:0] reg_lane;
	} redirect_t;

endpackage

/* hw/axil_pkg.sv */
// 32-bit data, 8-bit byte address; the register map assumes four strands at a stride of 4 bytes
package axil_pkg;

	localparam int AXIL_AW = 8;
	localparam int AXIL_DW = 32;

	typedef logic [1:0] axil_resp_t;

	localparam axil_resp_t RESP_OKAY = 2'b00;
	localparam axil_resp_t RESP_SLVERR = 2'b10;

	// master to slave
	typedef struct packed {
		logic awvalid;
		logic [AXIL_AW-1:0] awaddr;
		logic wvalid;
		logic [AXIL_DW-1:0] wdata;
		logic [AXIL_DW/8-1:0] wstrb;
		logic bready;
		logic arvalid;
		logic [AXIL_AW-1:0] araddr;
		logic rready;
	} axil_req_t;

	// slave to master
	typedef struct packed {
		logic awready;
		logic wready;
		logic bvalid;
		axil_resp_t bresp;
		logic arready;
		logic rvalid;
		logic [AXIL_DW-1:0] rdata;
		axil_resp_t rresp;
	} axil_rsp_t;

	// register map
	// suspend mask, read only
	localparam logic [AXIL_AW-1:0] REG_SUSPEND = 8'h00;
	// write 1s to resume strands
	localparam logic [AXIL_AW-1:0] REG_RESUME = 8'h04;
	// one rollback counter per strand
	localparam logic [AXIL_AW-1:0] REG_COUNT_BASE = 8'h10;
	// one last redirect pc per strand
	localparam logic [AXIL_AW-1:0] REG_PC_BASE = 8'h20;

endpackage

/* hw/rollback_controller.sv */
// purely combinational; the requesting stage flushes itself, and clk only clocks the checks
`timescale 1ns/100ps

module rollback_controller (
	input logic clk,
	input rb_pipe_pkg::stage_strands_t stage_strands,
	input rb_pipe_pkg::ex_rollback_t ex_req,
	input rb_pipe_pkg::wb_rollback_t wb_req,
	output rb_pipe_pkg::flush_t flush,
	output rb_pipe_pkg::redirect_t redirect [rb_pipe_pkg::NUM_STRANDS]
);
	import rb_pipe_pkg::*;

	// one-hot strand hit per request source
	logic [NUM_STRANDS-1:0] wb_hit;
	logic [NUM_STRANDS-1:0] ex_hit;
	// any rollback on a strand
	logic [NUM_STRANDS-1:0] rb_hit;

	function automatic logic [NUM_STRANDS-1:0] strand_dec(input strand_t s);
		logic [NUM_STRANDS-1:0] v;
		v = '0;
		v[s] = 1'b1;
		return v;
	endfunction

	// wb targets the strand in memory access, ex the strand in decode
	assign wb_hit = wb_req.valid ? strand_dec(stage_strands.ma) : '0;
	assign ex_hit = ex_req.valid ? strand_dec(stage_strands.ds) : '0;
	assign rb_hit = wb_hit | ex_hit;

	// only younger stages of the same strand are flushed
	always_comb
	begin
		// ex requests reach back to decode only
		flush.ds = |(rb_hit & strand_dec(stage_strands.ss));
		// wb requests also clear the execute path and memory access
		flush.ex0 = |(wb_hit & strand_dec(stage_strands.ds));
		flush.ex1 = |(wb_hit & strand_dec(stage_strands.ex1));
		flush.ex2 = |(wb_hit & strand_dec(stage_strands.ex2));
		flush.ex3 = |(wb_hit & strand_dec(stage_strands.ex3));
		flush.ma = |(wb_hit & strand_dec(stage_strands.ex));
	end

	// writeback wins the payload over execute
	always_comb
	begin
		for (int i = 0; i < NUM_STRANDS; i++)
		begin
			redirect[i].rollback = rb_hit[i];
			if (wb_hit[i])
			begin
				redirect[i].retry = wb_req.retry;
				redirect[i].suspend = wb_req.suspend;
				redirect[i].pc = wb_req.pc;
				redirect[i].strided_offset = wb_req.strided_offset;
				redirect[i].reg_lane = wb_req.reg_lane;
			end
			else
			begin
				// ex-sourced or idle strands restart at the branch target
				redirect[i].retry = 1'b0;
				redirect[i].suspend = 1'b0;
				redirect[i].pc = ex_req.pc;
				redirect[i].strided_offset = '0;
				redirect[i].reg_lane = '0;
			end
		end
	end

	// decode flush must trace back to a live request aimed at the ss strand
	a_ds_has_source: assert property (@(posedge clk)
		flush.ds |-> ((ex_req.valid && stage_strands.ss == stage_strands.ds)
			|| (wb_req.valid && stage_strands.ss == stage_strands.ma)))
		else $error("decode flushed with no rollback request");

	// execute and memory stages only flush from writeback on a matching strand
	a_late_flush_from_wb: assert property (@(posedge clk)
		(flush.ex0 || flush.ex1 || flush.ex2 || flush.ex3 || flush.ma) |-> (wb_req.valid
			&& (!flush.ex0 || stage_strands.ds == stage_strands.ma)
			&& (!flush.ex1 || stage_strands.ex1 == stage_strands.ma)
			&& (!flush.ex2 || stage_strands.ex2 == stage_strands.ma)
			&& (!flush.ex3 || stage_strands.ex3 == stage_strands.ma)
			&& (!flush.ma || stage_strands.ex == stage_strands.ma)))
		else $error("execute or memory flushed without a writeback rollback");

endmodule

/* hw/strand_state.sv */
// counters wrap silently; a suspend arriving with a resume for the same strand keeps it suspended
`timescale 1ns/100ps

module strand_state (
	input logic clk,
	input logic rst_n,
	input rb_pipe_pkg::redirect_t redirect [rb_pipe_pkg::NUM_STRANDS],
	input logic resume,
	input logic [rb_pipe_pkg::NUM_STRANDS-1:0] resume_mask,
	output logic [rb_pipe_pkg::NUM_STRANDS-1:0] suspended,
	output logic [rb_pipe_pkg::CNT_W-1:0] rb_count [rb_pipe_pkg::NUM_STRANDS],
	output logic [rb_pipe_pkg::PC_W-1:0] last_pc [rb_pipe_pkg::NUM_STRANDS]
);
	import rb_pipe_pkg::*;

	// per-strand bookkeeping, updated on the edge after the redirect
	always_ff @(posedge clk)
	begin
		for (int i = 0; i < NUM_STRANDS; i++)
		begin
			if (!rst_n)
			begin
				suspended[i] <= 1'b0;
				rb_count[i] <= '0;
				last_pc[i] <= '0;
			end
			else
			begin
				// one count per rollback cycle, restart pc kept for software
				if (redirect[i].rollback)
				begin
					last_pc[i] <= redirect[i].pc;
					rb_count[i] <= rb_count[i] + 1'b1;
				end

				// new suspend takes priority over a resume in the same cycle
				if (redirect[i].rollback && redirect[i].suspend)
				begin
					suspended[i] <= 1'b1;
				end
				else if (resume && resume_mask[i])
				begin
					suspended[i] <= 1'b0;
				end
			end
		end
	end

	// a strand only parks itself through a writeback suspend
	for (genvar g = 0; g < NUM_STRANDS; g++)
	begin : g_susp_chk
		a_susp_source: assert property (@(posedge clk) disable iff (!rst_n)
			$rose(suspended[g]) |-> $past(redirect[g].rollback && redirect[g].suspend))
			else $error("strand %0d suspended without a suspend redirect", g);
	end

endmodule

/* hw/rollback_csr.sv */
// one outstanding write and one outstanding read; only REG_RESUME is writable, byte 0 must be strobed
`timescale 1ns/100ps

module rollback_csr (
	input logic clk,
	input logic rst_n,
	input axil_pkg::axil_req_t axil_in,
	output axil_pkg::axil_rsp_t axil_out,
	input logic [rb_pipe_pkg::NUM_STRANDS-1:0] suspended,
	input logic [rb_pipe_pkg::CNT_W-1:0] rb_count [rb_pipe_pkg::NUM_STRANDS],
	input logic [rb_pipe_pkg::PC_W-1:0] last_pc [rb_pipe_pkg::NUM_STRANDS],
	output logic resume,
	output logic [rb_pipe_pkg::NUM_STRANDS-1:0] resume_mask
);
	import rb_pipe_pkg::*;
	import axil_pkg::*;

	// write channel state
	logic aw_got;
	logic w_got;
	logic [AXIL_AW-1:0] awaddr_q;
	logic [AXIL_DW-1:0] wdata_q;
	logic [AXIL_DW/8-1:0] wstrb_q;
	logic bvalid;
	axil_resp_t bresp;

	// read channel state
	logic rvalid;
	logic [AXIL_DW-1:0] rdata;
	axil_resp_t rresp;

	logic awready;
	logic wready;
	logic arready;
	logic aw_fire;
	logic w_fire;
	logic ar_fire;
	logic wr_commit;
	logic wr_is_resume;
	logic [AXIL_AW-1:0] wr_addr;
	logic [AXIL_DW-1:0] wr_data;
	logic [AXIL_DW/8-1:0] wr_strb;
	logic [AXIL_AW-1:0] cnt_off;
	logic [AXIL_AW-1:0] pc_off;
	logic [AXIL_DW-1:0] rd_data;
	logic rd_err;

	// no new beats while a response is still waiting
	assign awready = !aw_got && !bvalid;
	assign wready = !w_got && !bvalid;
	assign arready = !rvalid;

	assign aw_fire = axil_in.awvalid && awready;
	assign w_fire = axil_in.wvalid && wready;
	assign ar_fire = axil_in.arvalid && arready;

	// address and data may land in either order or together
	assign wr_commit = (aw_got || aw_fire) && (w_got || w_fire);
	assign wr_addr = aw_got ? awaddr_q : axil_in.awaddr;
	assign wr_data = w_got ? wdata_q : axil_in.wdata;
	assign wr_strb = w_got ? wstrb_q : axil_in.wstrb;
	assign wr_is_resume = (wr_addr == REG_RESUME);

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			aw_got <= 1'b0;
			w_got <= 1'b0;
			bvalid <= 1'b0;
			resume <= 1'b0;
		end
		else
		begin
			// resume is a single-cycle strobe
			resume <= 1'b0;
			if (wr_commit)
			begin
				aw_got <= 1'b0;
				w_got <= 1'b0;
				bvalid <= 1'b1;
				resume <= wr_is_resume && wr_strb[0];
			end
			else
			begin
				if (aw_fire)
					aw_got <= 1'b1;
				if (w_fire)
					w_got <= 1'b1;
			end
			if (bvalid && axil_in.bready)
				bvalid <= 1'b0;
		end
	end

	// held write beats and response payload
	always_ff @(posedge clk)
	begin
		if (aw_fire)
			awaddr_q <= axil_in.awaddr;
		if (w_fire)
		begin
			wdata_q <= axil_in.wdata;
			wstrb_q <= axil_in.wstrb;
		end
		if (wr_commit)
		begin
			bresp <= wr_is_resume ? RESP_OKAY : RESP_SLVERR;
			resume_mask <= wr_data[NUM_STRANDS-1:0];
		end
	end

	// read decode, offsets relative to each array base
	always_comb
	begin
		cnt_off = axil_in.araddr - REG_COUNT_BASE;
		pc_off = axil_in.araddr - REG_PC_BASE;
		rd_data = '0;
		rd_err = 1'b0;
		if (axil_in.araddr == REG_SUSPEND)
			rd_data = AXIL_DW'(suspended);
		else if (cnt_off < NUM_STRANDS * 4 && cnt_off[1:0] == 2'b00)
			rd_data = AXIL_DW'(rb_count[cnt_off[STRAND_W+1:2]]);
		else if (pc_off < NUM_STRANDS * 4 && pc_off[1:0] == 2'b00)
			rd_data = AXIL_DW'(last_pc[pc_off[STRAND_W+1:2]]);
		else
			rd_err = 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			rvalid <= 1'b0;
		else if (ar_fire)
			rvalid <= 1'b1;
		else if (rvalid && axil_in.rready)
			rvalid <= 1'b0;
	end

	// data is sampled at accept and held until rready
	always_ff @(posedge clk)
	begin
		if (ar_fire)
		begin
			rdata <= rd_data;
			rresp <= rd_err ? RESP_SLVERR : RESP_OKAY;
		end
	end

	always_comb
	begin
		axil_out.awready = awready;
		axil_out.wready = wready;
		axil_out.bvalid = bvalid;
		axil_out.bresp = bresp;
		axil_out.arready = arready;
		axil_out.rvalid = rvalid;
		axil_out.rdata = rdata;
		axil_out.rresp = rresp;
	end

	// responses hold under back-pressure
	a_b_hold: assert property (@(posedge clk) disable iff (!rst_n)
		(bvalid && !axil_in.bready) |=> (bvalid && $stable(bresp)))
		else $error("write response dropped or changed before bready");

	a_r_hold: assert property (@(posedge clk) disable iff (!rst_n)
		(rvalid && !axil_in.rready) |=> (rvalid && $stable(rdata) && $stable(rresp)))
		else $error("read data dropped or changed before rready");

endmodule

/* hw/rollback_unit_top.sv */
// flush and redirect are combinational from the requests; strand state lags by one clock
`timescale 1ns/100ps

module rollback_unit_top (
	input logic clk,
	input logic rst_n,
	input rb_pipe_pkg::stage_strands_t stage_strands,
	input rb_pipe_pkg::ex_rollback_t ex_req,
	input rb_pipe_pkg::wb_rollback_t wb_req,
	output rb_pipe_pkg::flush_t flush,
	output rb_pipe_pkg::redirect_t redirect [rb_pipe_pkg::NUM_STRANDS],
	input axil_pkg::axil_req_t axil_in,
	output axil_pkg::axil_rsp_t axil_out
);
	import rb_pipe_pkg::*;

	// strand state towards software
	logic [NUM_STRANDS-1:0] suspended;
	logic [CNT_W-1:0] rb_count [NUM_STRANDS];
	logic [PC_W-1:0] last_pc [NUM_STRANDS];
	// software resume towards strand state
	logic resume;
	logic [NUM_STRANDS-1:0] resume_mask;

	// clk here only clocks the checks
	rollback_controller rollback_controller_inst (
		.clk(clk),
		.stage_strands(stage_strands),
		.ex_req(ex_req),
		.wb_req(wb_req),
		.flush(flush),
		.redirect(redirect)
	);

	strand_state strand_state_inst (
		.clk(clk),
		.rst_n(rst_n),
		.redirect(redirect),
		.resume(resume),
		.resume_mask(resume_mask),
		.suspended(suspended),
		.rb_count(rb_count),
		.last_pc(last_pc)
	);

	rollback_csr rollback_csr_inst (
		.clk(clk),
		.rst_n(rst_n),
		.axil_in(axil_in),
		.axil_out(axil_out),
		.suspended(suspended),
		.rb_count(rb_count),
		.last_pc(last_pc),
		.resume(resume),
		.resume_mask(resume_mask)
	);

endmodule

/* include/rb_tb_model.svh */
// included inside the testbench module; expects its request signals, bus signals, clk and counters
`ifndef RB_TB_MODEL_SVH
`define RB_TB_MODEL_SVH

	// expected combinational outputs for the current cycle
	flush_t exp_flush;
	redirect_t exp_redir [NUM_STRANDS];
	// shadow of the registered strand state
	logic [NUM_STRANDS-1:0] exp_susp;
	logic [CNT_W-1:0] exp_cnt [NUM_STRANDS];
	logic [PC_W-1:0] exp_pc [NUM_STRANDS];

	task automatic model_reset();
		exp_susp = '0;
		for (int i = 0; i < NUM_STRANDS; i++)
		begin
			exp_cnt[i] = '0;
			exp_pc[i] = '0;
		end
	endtask

	// wb targets the ma strand, ex the ds strand
	task automatic model_eval();
		int wbs;
		int exs;
		logic wb_on;
		logic ex_on;
		wbs = int'(stage_strands.ma);
		exs = int'(stage_strands.ds);
		exp_flush = '0;
		for (int i = 0; i < NUM_STRANDS; i++)
		begin
			wb_on = wb_req.valid && (wbs == i);
			ex_on = ex_req.valid && (exs == i);
			exp_redir[i] = '0;
			exp_redir[i].rollback = wb_on || ex_on;
			// writeback owns the payload when both hit
			if (wb_on)
			begin
				exp_redir[i].retry = wb_req.retry;
				exp_redir[i].suspend = wb_req.suspend;
				exp_redir[i].pc = wb_req.pc;
				exp_redir[i].strided_offset = wb_req.strided_offset;
				exp_redir[i].reg_lane = wb_req.reg_lane;
			end
			else if (ex_on)
				exp_redir[i].pc = ex_req.pc;
			// decode flush for any rollback on the ss strand
			if ((wb_on || ex_on) && int'(stage_strands.ss) == i)
				exp_flush.ds = 1'b1;
		end
		// later stages only flush on writeback
		if (wb_req.valid)
		begin
			exp_flush.ma = (int'(stage_strands.ex) == wbs);
			exp_flush.ex0 = (int'(stage_strands.ds) == wbs);
			exp_flush.ex1 = (int'(stage_strands.ex1) == wbs);
			exp_flush.ex2 = (int'(stage_strands.ex2) == wbs);
			exp_flush.ex3 = (int'(stage_strands.ex3) == wbs);
		end
	endtask

	// state the DUT latches at the next edge
	task automatic model_commit();
		for (int i = 0; i < NUM_STRANDS; i++)
		begin
			if (exp_redir[i].rollback)
			begin
				exp_pc[i] = exp_redir[i].pc;
				exp_cnt[i] = exp_cnt[i] + 1;
				if (exp_redir[i].suspend)
					exp_susp[i] = 1'b1;
			end
		end
	endtask

	// address and data offered together, bready held low for hold cycles
	task automatic axil_write(input logic [AXIL_AW-1:0] addr, input logic [31:0] data,
		input int hold, output axil_resp_t resp);
		logic aw_done;
		logic w_done;
		aw_done = 1'b0;
		w_done = 1'b0;
		@(posedge clk);
		axil_in.awvalid <= 1'b1;
		axil_in.awaddr <= addr;
		axil_in.wvalid <= 1'b1;
		axil_in.wdata <= data;
		axil_in.wstrb <= 4'hf;
		while (!(aw_done && w_done))
		begin
			@(negedge clk);
			if (!aw_done && axil_out.awready)
				aw_done = 1'b1;
			if (!w_done && axil_out.wready)
				w_done = 1'b1;
			@(posedge clk);
			if (aw_done)
				axil_in.awvalid <= 1'b0;
			if (w_done)
				axil_in.wvalid <= 1'b0;
		end
		@(negedge clk);
		while (!axil_out.bvalid)
			@(negedge clk);
		resp = axil_out.bresp;
		// response must hold while the master stalls
		repeat (hold)
		begin
			@(negedge clk);
			if (!axil_out.bvalid)
			begin
				n_errors++;
				$display("bvalid dropped while bready was held low");
			end
			compare_word("bresp", 32'(resp), 32'(axil_out.bresp));
		end
		@(posedge clk);
		axil_in.bready <= 1'b1;
		@(posedge clk);
		axil_in.bready <= 1'b0;
	endtask

	// rready held low for hold cycles after rvalid
	task automatic axil_read(input logic [AXIL_AW-1:0] addr, input int hold,
		output logic [31:0] data, output axil_resp_t resp);
		logic ar_done;
		ar_done = 1'b0;
		@(posedge clk);
		axil_in.arvalid <= 1'b1;
		axil_in.araddr <= addr;
		while (!ar_done)
		begin
			@(negedge clk);
			if (axil_out.arready)
				ar_done = 1'b1;
			@(posedge clk);
			if (ar_done)
				axil_in.arvalid <= 1'b0;
		end
		@(negedge clk);
		while (!axil_out.rvalid)
			@(negedge clk);
		data = axil_out.rdata;
		resp = axil_out.rresp;
		repeat (hold)
		begin
			@(negedge clk);
			if (!axil_out.rvalid)
			begin
				n_errors++;
				$display("rvalid dropped while rready was held low");
			end
			compare_word("rdata", data, axil_out.rdata);
			compare_word("rresp", 32'(resp), 32'(axil_out.rresp));
		end
		@(posedge clk);
		axil_in.rready <= 1'b1;
		@(posedge clk);
		axil_in.rready <= 1'b0;
	endtask

`endif

/* dv/rollback_tb.sv */
// one fixed LFSR seed, so the run repeats; idle strands only have their rollback bit compared
`timescale 1ns/100ps

module rollback_tb;
	import rb_pipe_pkg::*;
	import axil_pkg::*;

	localparam int CLK_PERIOD = 40;
	localparam int RESET_CYCLES = 3;
	localparam int RAND_CYCLES = 400;
	// bus transactions after the random phase, each a bounded number of cycles
	localparam int AXI_OPS = 16;
	localparam int AXI_OP_CYCLES = 16;
	localparam int RUN_CYCLES = RESET_CYCLES + RAND_CYCLES + AXI_OPS * AXI_OP_CYCLES;
	localparam int WATCHDOG_NS = RUN_CYCLES * CLK_PERIOD * 4;

	logic clk;
	logic rst_n;
	stage_strands_t stage_strands;
	ex_rollback_t ex_req;
	wb_rollback_t wb_req;
	flush_t flush;
	redirect_t redirect [NUM_STRANDS];
	axil_req_t axil_in;
	axil_rsp_t axil_out;

	logic [15:0] lfsr;
	int n_errors;
	int n_checks;

	// fibonacci lfsr, taps 16 14 13 11, one step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		logic fb;
		r = '0;
		for (int k = 0; k < n; k++)
		begin
			fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
			lfsr = {lfsr[14:0], fb};
			r = {r[30:0], fb};
		end
		return r;
	endfunction

	task automatic compare_word(input string name, input logic [31:0] exp,
		input logic [31:0] got);
		n_checks++;
		if (got !== exp)
		begin
			n_errors++;
			$display("CHECK FAILED %s exp %h got %h", name, exp, got);
		end
	endtask

	`include "rb_tb_model.svh"

	// valid bits come up 3 times in 8
	task automatic drive_random();
		logic [31:0] r;
		ex_rollback_t ex_v;
		wb_rollback_t wb_v;
		r = rand_bits(14);
		stage_strands <= r[13:0];
		ex_v.valid = (rand_bits(3) < 3);
		ex_v.pc = rand_bits(32);
		wb_v.valid = (rand_bits(3) < 3);
		r = rand_bits(2);
		wb_v.retry = r[0];
		wb_v.suspend = r[1];
		wb_v.pc = rand_bits(32);
		wb_v.strided_offset = rand_bits(32);
		r = rand_bits(4);
		wb_v.reg_lane = r[3:0];
		ex_req <= ex_v;
		wb_req <= wb_v;
	endtask

	task automatic check_outputs();
		compare_word("flush", 32'(exp_flush), 32'(flush));
		for (int i = 0; i < NUM_STRANDS; i++)
		begin
			n_checks++;
			if (redirect[i].rollback !== exp_redir[i].rollback)
			begin
				n_errors++;
				$display("CHECK FAILED redirect[%0d].rollback exp %h got %h", i,
					exp_redir[i].rollback, redirect[i].rollback);
			end
			else if (exp_redir[i].rollback && redirect[i] !== exp_redir[i])
			begin
				n_errors++;
				$display("CHECK FAILED redirect[%0d] exp %h got %h", i,
					exp_redir[i], redirect[i]);
			end
		end
	endtask

	rollback_unit_top rollback_unit_top_inst (
		.clk(clk),
		.rst_n(rst_n),
		.stage_strands(stage_strands),
		.ex_req(ex_req),
		.wb_req(wb_req),
		.flush(flush),
		.redirect(redirect),
		.axil_in(axil_in),
		.axil_out(axil_out)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#(CLK_PERIOD / 2) clk = ~clk;
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("watchdog expired before the test sequence finished");
		$display("checks %0d errors %0d", n_checks, n_errors);
		$display("STATUS: FAIL");
		$finish;
	end

	initial
	begin
		logic [31:0] rd;
		axil_resp_t resp;
		logic [3:0] mask;
		rst_n = 1'b0;
		stage_strands = '0;
		ex_req = '0;
		wb_req = '0;
		axil_in = '0;
		lfsr = 16'd39;
		n_errors = 0;
		n_checks = 0;
		model_reset();
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;

		// outputs are combinational, so check mid-cycle
		for (int c = 0; c < RAND_CYCLES; c++)
		begin
			@(posedge clk);
			drive_random();
			@(negedge clk);
			model_eval();
			check_outputs();
			model_commit();
		end
		@(posedge clk);
		ex_req <= '0;
		wb_req <= '0;

		for (int i = 0; i < NUM_STRANDS; i++)
		begin
			axil_read(REG_COUNT_BASE + 8'(4 * i), 0, rd, resp);
			compare_word($sformatf("rb_count[%0d]", i), exp_cnt[i], rd);
			compare_word("rresp", 32'(RESP_OKAY), 32'(resp));
			axil_read(REG_PC_BASE + 8'(4 * i), 0, rd, resp);
			compare_word($sformatf("last_pc[%0d]", i), exp_pc[i], rd);
		end

		// resume half the strands, then the other half, stalling bready each time
		for (int m = 0; m < 2; m++)
		begin
			mask = (m == 0) ? 4'b0101 : 4'b1010;
			axil_read(REG_SUSPEND, 0, rd, resp);
			compare_word("suspended", 32'(exp_susp), rd);
			axil_write(REG_RESUME, 32'(mask), 5, resp);
			compare_word("bresp", 32'(RESP_OKAY), 32'(resp));
			exp_susp = exp_susp & ~mask;
		end
		axil_read(REG_SUSPEND, 0, rd, resp);
		compare_word("suspended", 32'(exp_susp), rd);

		// stalled read keeps its data
		axil_read(REG_PC_BASE, 6, rd, resp);
		compare_word("last_pc[0]", exp_pc[0], rd);

		// holes in the map
		axil_read(8'h08, 0, rd, resp);
		compare_word("rresp", 32'(RESP_SLVERR), 32'(resp));
		axil_read(8'h3c, 0, rd, resp);
		compare_word("rresp", 32'(RESP_SLVERR), 32'(resp));

		$display("checks %0d errors %0d", n_checks, n_errors);
		if (n_errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

/* project.f */
+incdir+include
hw/rb_pipe_pkg.sv
hw/axil_pkg.sv
hw/rollback_controller.sv
hw/strand_state.sv
hw/rollback_csr.sv
hw/rollback_unit_top.sv
dv/rollback_tb.sv
